// File: common/vpu_params.svh
// Widths and register counts are fixed by the control address map and are not meant to be retuned
`ifndef VPU_PARAMS_SVH
`define VPU_PARAMS_SVH

// data width of every register and host port
`define VPU_WORD_W 32

// control space, 6-bit address
`define VPU_NUM_CTLREGS 64

// bank sizes inside the control space
`define VPU_NUM_VCREGS 32
`define VPU_NUM_VBASEREGS 16
`define VPU_NUM_VINCREGS 8
`define VPU_NUM_VSTRIDEREGS 8

// scalar bank, 5-bit address
`define VPU_NUM_VSREGS 32

// maximum vector length
`define VPU_MVL 64

// major opcode of a coprocessor instruction
`define VPU_COP2_FIELD 6'b010010

`endif

// File: common/vpu_pkg.sv
// Opcode values are local to this design and only the listed operations are recognised
`default_nettype none

package vpu_pkg;

  // {instr[25:22], instr[5:0]}
  typedef enum logic [9:0] {
    OP_NOP    = 10'b0000_000000,
    OP_VHALF  = 10'b1000_000010,
    OP_VSATVL = 10'b1000_000011,
    OP_VMSTC  = 10'b1111_000001,
    OP_VMCTS  = 10'b1111_000010,
    OP_CFC2   = 10'b1111_000011,
    OP_CTC2   = 10'b1111_000100,
    OP_MTC2   = 10'b1111_000101
  } vctl_op_e;

  // control form used by ctc2, cfc2, vmstc and vmcts
  typedef struct packed {
    logic [5:0] cop2;
    logic [3:0] op_hi;
    logic       rsv;
    logic [4:0] rt;
    logic [5:0] vcr;
    logic [3:0] spare;
    logic [5:0] op_lo;
  } vctl_ctl_fmt_t;

  // move form used by mtc2, scalar register in the upper vcr bits
  typedef struct packed {
    logic [5:0] cop2;
    logic [3:0] op_hi;
    logic       rsv;
    logic [4:0] rt;
    logic [4:0] vsr;
    logic [4:0] spare;
    logic [5:0] op_lo;
  } vctl_mv_fmt_t;

  typedef union packed {
    vctl_ctl_fmt_t ctl;
    vctl_mv_fmt_t  mv;
  } vctl_instr_u;

  // from the top three bits of a control address
  typedef enum logic [1:0] {
    BANK_VC      = 2'd0,
    BANK_VBASE   = 2'd1,
    BANK_VINC    = 2'd2,
    BANK_VSTRIDE = 2'd3
  } vctl_bank_e;

endpackage

`default_nettype wire

// File: ctlregs/vctl_regfile.sv
// Reset clears every entry. A read and a write of one entry in the same cycle return the old value.
`timescale 1ns/1ps
`default_nettype none

module vctl_regfile #(
  parameter int DEPTH = 32,
  parameter int WIDTH = 32
) (
  input  logic                     clk,
  input  logic                     resetn,
  input  logic [$clog2(DEPTH)-1:0] rd_addr,
  input  logic                     rd_en,
  output logic [WIDTH-1:0]         rd_data,
  input  logic [$clog2(DEPTH)-1:0] wr_addr,
  input  logic                     wr_en,
  input  logic [WIDTH-1:0]         wr_data,
  output logic [WIDTH-1:0]         reg0
);

  logic [WIDTH-1:0] mem [DEPTH];

  // read data holds while rd_en is low
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      for (int i = 0; i < DEPTH; i++)
        mem[i] <= '0;
      rd_data <= '0;
    end
    else
    begin
      if (wr_en)
        mem[wr_addr] <= wr_data;
      if (rd_en)
        rd_data <= mem[rd_addr];
    end
  end

  assign reg0 = mem[0];

endmodule

`default_nettype wire

// File: ctlregs/vctl_regbank.sv
// Address map is fixed at vc 0-31, vbase 32-47, vinc 48-55 and vstride 56-63. All are writable.
`timescale 1ns/1ps
`default_nettype none
`include "vpu_params.svh"

module vctl_regbank (
  input  logic                                clk,
  input  logic                                resetn,
  input  logic [$clog2(`VPU_NUM_CTLREGS)-1:0] ctl_rd_addr,
  input  logic                                ctl_rd_en,
  input  logic [$clog2(`VPU_NUM_VSREGS)-1:0]  vs_rd_addr,
  input  logic                                vs_rd_en,
  input  logic                                fwd_s2,
  input  logic [`VPU_WORD_W-1:0]              fwd_data,
  input  logic [$clog2(`VPU_NUM_CTLREGS)-1:0] ctl_wr_addr,
  input  logic                                ctl_wr_en,
  input  logic [`VPU_WORD_W-1:0]              ctl_wr_data,
  input  logic [$clog2(`VPU_NUM_VSREGS)-1:0]  vs_wr_addr,
  input  logic                                vs_wr_en,
  input  logic [`VPU_WORD_W-1:0]              vs_wr_data,
  output logic [`VPU_WORD_W-1:0]              ctl_rd_data,
  output logic [`VPU_WORD_W-1:0]              vs_rd_data,
  output logic [`VPU_WORD_W-1:0]              vl
);

  localparam int W = `VPU_WORD_W;
  localparam int CTL_AW = $clog2(`VPU_NUM_CTLREGS);

  logic [W-1:0]        bank_rd [4];
  logic [W-1:0]        bank_reg0 [4];
  vpu_pkg::vctl_bank_e rd_bank;
  vpu_pkg::vctl_bank_e wr_bank;
  vpu_pkg::vctl_bank_e rd_bank_q;
  logic [W-1:0]        fwd_q;

  function automatic vpu_pkg::vctl_bank_e bank_of(input logic [CTL_AW-1:0] addr);
    if (!addr[CTL_AW-1])
      return vpu_pkg::BANK_VC;
    else if (!addr[CTL_AW-2])
      return vpu_pkg::BANK_VBASE;
    else if (!addr[CTL_AW-3])
      return vpu_pkg::BANK_VINC;
    else
      return vpu_pkg::BANK_VSTRIDE;
  endfunction

  assign rd_bank = bank_of(ctl_rd_addr);
  assign wr_bank = bank_of(ctl_wr_addr);

  // one file per bank, indexed by the low address bits
  for (genvar b = 0; b < 4; b++)
  begin : g_bank
    localparam int DEPTH = (b == 0) ? `VPU_NUM_VCREGS :
                           (b == 1) ? `VPU_NUM_VBASEREGS :
                           (b == 2) ? `VPU_NUM_VINCREGS : `VPU_NUM_VSTRIDEREGS;
    localparam int AW = $clog2(DEPTH);

    vctl_regfile #(.DEPTH(DEPTH), .WIDTH(W)) u_rf (
      .clk     (clk),
      .resetn  (resetn),
      .rd_addr (ctl_rd_addr[AW-1:0]),
      .rd_en   (ctl_rd_en && (rd_bank == b)),
      .rd_data (bank_rd[b]),
      .wr_addr (ctl_wr_addr[AW-1:0]),
      .wr_en   (ctl_wr_en && (wr_bank == b)),
      .wr_data (ctl_wr_data),
      .reg0    (bank_reg0[b])
    );
  end

  vctl_regfile #(.DEPTH(`VPU_NUM_VSREGS), .WIDTH(W)) u_vs_rf (
    .clk     (clk),
    .resetn  (resetn),
    .rd_addr (vs_rd_addr),
    .rd_en   (vs_rd_en),
    .rd_data (vs_rd_data),
    .wr_addr (vs_wr_addr),
    .wr_en   (vs_wr_en),
    .wr_data (vs_wr_data),
    .reg0    ()
  );

  // bank select and stage-2 write value follow the read into stage 2
  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      rd_bank_q <= vpu_pkg::BANK_VC;
      fwd_q     <= '0;
    end
    else if (ctl_rd_en)
    begin
      rd_bank_q <= rd_bank;
      fwd_q     <= fwd_data;
    end
  end

  assign ctl_rd_data = fwd_s2 ? fwd_q : bank_rd[rd_bank_q];

  // vc0 is the vector length
  assign vl = bank_reg0[0];

endmodule

`default_nettype wire

// File: logic/vctl_decode.sv
// Non-coprocessor words and unknown opcodes enter stage 2 as nops. Scalar hazards stall coarsely.
`timescale 1ns/1ps
`default_nettype none
`include "vpu_params.svh"

module vctl_decode (
  input  logic                                   clk,
  input  logic                                   resetn,
  input  logic [`VPU_WORD_W-1:0]                 instr,
  input  logic                                   instr_en,
  output logic                                   instr_wait,
  input  logic                                   stall2,
  output logic                                   stall1,
  output logic [$clog2(`VPU_NUM_CTLREGS)-1:0]    ctl_rd_addr,
  output logic                                   ctl_rd_en,
  output logic [$clog2(`VPU_NUM_VSREGS)-1:0]     vs_rd_addr,
  output logic                                   vs_rd_en,
  output vpu_pkg::vctl_op_e                      op_s2,
  output logic [$clog2(`VPU_NUM_CTLREGS)-1:0]    ctl_dst_s2,
  output logic [$clog2(`VPU_NUM_VSREGS)-1:0]     vs_dst_s2,
  output logic                                   ctl_we_s2,
  output logic                                   vs_we_s2,
  output logic                                   fwd_s2
);

  vpu_pkg::vctl_instr_u                   ir;
  vpu_pkg::vctl_op_e                      op_s1;
  logic                                   is_cop2;
  logic                                   ctl_rd_s1;
  logic                                   vs_rd_s1;
  logic                                   ctl_we_s1;
  logic                                   vs_we_s1;
  logic [$clog2(`VPU_NUM_CTLREGS)-1:0]    ctl_dst_s1;
  logic [$clog2(`VPU_NUM_VSREGS)-1:0]     vs_dst_s1;
  logic                                   haz_ctl;
  logic                                   haz_vs;
  logic                                   bubble;

  assign is_cop2 = instr[`VPU_WORD_W-1 -: 6] == `VPU_COP2_FIELD;
  assign instr_wait = stall1 & is_cop2;

  // absent or foreign words become an all-zero nop
  always_ff @(posedge clk)
  begin
    if (!resetn)
      ir <= '0;
    else if (!stall1)
      ir <= (instr_en && is_cop2) ? instr : '0;
  end

  always_comb
  begin
    case ({ir.ctl.op_hi, ir.ctl.op_lo})
      vpu_pkg::OP_CTC2, vpu_pkg::OP_MTC2, vpu_pkg::OP_CFC2, vpu_pkg::OP_VMSTC,
      vpu_pkg::OP_VMCTS, vpu_pkg::OP_VHALF, vpu_pkg::OP_VSATVL:
        op_s1 = vpu_pkg::vctl_op_e'({ir.ctl.op_hi, ir.ctl.op_lo});
      default:
        op_s1 = vpu_pkg::OP_NOP;
    endcase
  end

  assign ctl_rd_s1 = op_s1 inside {vpu_pkg::OP_CFC2, vpu_pkg::OP_VMCTS};
  assign vs_rd_s1 = op_s1 == vpu_pkg::OP_VMSTC;
  assign ctl_we_s1 = op_s1 inside {vpu_pkg::OP_CTC2, vpu_pkg::OP_VMSTC,
                                   vpu_pkg::OP_VHALF, vpu_pkg::OP_VSATVL};
  assign vs_we_s1 = op_s1 inside {vpu_pkg::OP_MTC2, vpu_pkg::OP_VMCTS};

  // vhalf and vsatvl always target vc0, the vector length
  assign ctl_dst_s1 = (op_s1 inside {vpu_pkg::OP_VHALF, vpu_pkg::OP_VSATVL}) ? '0 : ir.ctl.vcr;
  assign vs_dst_s1 = (op_s1 == vpu_pkg::OP_MTC2) ? ir.mv.vsr : ir.ctl.rt;

  assign ctl_rd_addr = ir.ctl.vcr;
  assign vs_rd_addr = ir.ctl.rt;

  // control RAW is forwarded, scalar RAW waits for the write to land
  assign haz_ctl = ctl_rd_s1 & ctl_we_s2 & (ir.ctl.vcr == ctl_dst_s2);
  assign haz_vs = vs_rd_s1 & vs_we_s2;

  assign stall1 = stall2 | haz_vs;
  assign bubble = stall1 & ~stall2;
  assign ctl_rd_en = ctl_rd_s1 & ~stall1;
  assign vs_rd_en = vs_rd_s1 & ~stall1;

  always_ff @(posedge clk)
  begin
    if (!resetn || bubble)
    begin
      op_s2     <= vpu_pkg::OP_NOP;
      ctl_we_s2 <= 1'b0;
      vs_we_s2  <= 1'b0;
      fwd_s2    <= 1'b0;
    end
    else if (!stall1)
    begin
      op_s2     <= op_s1;
      ctl_we_s2 <= ctl_we_s1;
      vs_we_s2  <= vs_we_s1;
      fwd_s2    <= haz_ctl;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      ctl_dst_s2 <= '0;
      vs_dst_s2  <= '0;
    end
    else if (!stall1)
    begin
      ctl_dst_s2 <= ctl_dst_s1;
      vs_dst_s2  <= vs_dst_s1;
    end
  end

endmodule

`default_nettype wire

// File: logic/vctl_execute.sv
// Purely combinational stage 2. Writes commit at the edge that ends the stage, only when not stalled.
`timescale 1ns/1ps
`default_nettype none
`include "vpu_params.svh"

module vctl_execute (
  input  vpu_pkg::vctl_op_e                   op_s2,
  input  logic [$clog2(`VPU_NUM_CTLREGS)-1:0] ctl_dst_s2,
  input  logic [$clog2(`VPU_NUM_VSREGS)-1:0]  vs_dst_s2,
  input  logic                                ctl_we_s2,
  input  logic                                vs_we_s2,
  input  logic                                stall3,
  input  logic [`VPU_WORD_W-1:0]              scalar_in,
  input  logic                                scalar_in_en,
  input  logic [`VPU_WORD_W-1:0]              ctl_rd_data,
  input  logic [`VPU_WORD_W-1:0]              vs_rd_data,
  input  logic [`VPU_WORD_W-1:0]              vl,
  output logic                                stall2,
  output logic                                scalar_in_wait,
  output logic [$clog2(`VPU_NUM_CTLREGS)-1:0] ctl_wr_addr,
  output logic                                ctl_wr_en,
  output logic [`VPU_WORD_W-1:0]              ctl_wr_data,
  output logic [$clog2(`VPU_NUM_VSREGS)-1:0]  vs_wr_addr,
  output logic                                vs_wr_en,
  output logic [`VPU_WORD_W-1:0]              vs_wr_data,
  output logic [`VPU_WORD_W-1:0]              fwd_data
);

  localparam logic [`VPU_WORD_W-1:0] MVL = `VPU_WORD_W'(`VPU_MVL);

  logic                   needs_in;
  logic [`VPU_WORD_W-1:0] wr_data;

  // ctc2 and mtc2 sit here until the host supplies the value
  assign needs_in = op_s2 inside {vpu_pkg::OP_CTC2, vpu_pkg::OP_MTC2};
  assign stall2 = stall3 | (needs_in & ~scalar_in_en);
  assign scalar_in_wait = (scalar_in_en & ~needs_in) | (needs_in & scalar_in_en & stall2);

  always_comb
  begin
    case (op_s2)
      vpu_pkg::OP_CTC2, vpu_pkg::OP_MTC2:
        wr_data = scalar_in;
      vpu_pkg::OP_VMSTC:
        wr_data = vs_rd_data;
      vpu_pkg::OP_VMCTS:
        wr_data = ctl_rd_data;
      vpu_pkg::OP_VHALF:
        wr_data = vl >> 1;
      // clamp vl to the hardware maximum
      vpu_pkg::OP_VSATVL:
        wr_data = (vl > MVL) ? MVL : vl;
      default:
        wr_data = '0;
    endcase
  end

  assign ctl_wr_addr = ctl_dst_s2;
  assign ctl_wr_en = ctl_we_s2 & ~stall2;
  assign ctl_wr_data = wr_data;

  assign vs_wr_addr = vs_dst_s2;
  assign vs_wr_en = vs_we_s2 & ~stall2;
  assign vs_wr_data = wr_data;

  assign fwd_data = wr_data;

endmodule

`default_nettype wire

// File: logic/scalar_out_port.sv
// Each cfc2 result is strobed once. Stage 3 holds one extra cycle after the host takes it.
`timescale 1ns/1ps
`default_nettype none
`include "vpu_params.svh"

module scalar_out_port (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic                   cfc_s2,
  input  logic [`VPU_WORD_W-1:0] ctl_rd_data,
  input  logic                   stall2,
  input  logic                   scalar_out_wait,
  output logic [`VPU_WORD_W-1:0] scalar_out,
  output logic                   scalar_out_en,
  output logic                   stall3
);

  logic valid_s3;
  logic satisfied;
  logic accept;

  assign accept = valid_s3 & ~satisfied & ~scalar_out_wait;
  assign scalar_out_en = valid_s3 & ~satisfied;
  // hold until taken, then one more cycle so the strobe can drop
  assign stall3 = valid_s3 & (scalar_out_wait | ~satisfied);

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      valid_s3  <= 1'b0;
      satisfied <= 1'b0;
    end
    else if (!stall3)
    begin
      valid_s3  <= cfc_s2 & ~stall2;
      satisfied <= 1'b0;
    end
    else if (accept)
      satisfied <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (!resetn)
      scalar_out <= '0;
    else if (cfc_s2 && !stall2)
      scalar_out <= ctl_rd_data;
  end

endmodule

`default_nettype wire

// File: logic/vctl_top.sv
// Scalar-side control pipeline only. There are no vector lanes and no data bus.
`timescale 1ns/1ps
`default_nettype none
`include "vpu_params.svh"

module vctl_top (
  input  logic                   clk,
  input  logic                   resetn,
  input  logic [`VPU_WORD_W-1:0] instr,
  input  logic                   instr_en,
  output logic                   instr_wait,
  input  logic [`VPU_WORD_W-1:0] scalar_in,
  input  logic                   scalar_in_en,
  output logic                   scalar_in_wait,
  output logic [`VPU_WORD_W-1:0] scalar_out,
  output logic                   scalar_out_en,
  input  logic                   scalar_out_wait
);

  logic                                stall1;
  logic                                stall2;
  logic                                stall3;
  logic [$clog2(`VPU_NUM_CTLREGS)-1:0] ctl_rd_addr;
  logic                                ctl_rd_en;
  logic [$clog2(`VPU_NUM_VSREGS)-1:0]  vs_rd_addr;
  logic                                vs_rd_en;
  vpu_pkg::vctl_op_e                   op_s2;
  logic [$clog2(`VPU_NUM_CTLREGS)-1:0] ctl_dst_s2;
  logic [$clog2(`VPU_NUM_VSREGS)-1:0]  vs_dst_s2;
  logic                                ctl_we_s2;
  logic                                vs_we_s2;
  logic                                fwd_s2;
  logic                                cfc_s2;
  logic [`VPU_WORD_W-1:0]              fwd_data;
  logic [$clog2(`VPU_NUM_CTLREGS)-1:0] ctl_wr_addr;
  logic                                ctl_wr_en;
  logic [`VPU_WORD_W-1:0]              ctl_wr_data;
  logic [$clog2(`VPU_NUM_VSREGS)-1:0]  vs_wr_addr;
  logic                                vs_wr_en;
  logic [`VPU_WORD_W-1:0]              vs_wr_data;
  logic [`VPU_WORD_W-1:0]              ctl_rd_data;
  logic [`VPU_WORD_W-1:0]              vs_rd_data;
  logic [`VPU_WORD_W-1:0]              vl;

  assign cfc_s2 = op_s2 == vpu_pkg::OP_CFC2;

  vctl_decode u_decode (
    .clk(clk), .resetn(resetn), .instr(instr), .instr_en(instr_en),
    .instr_wait(instr_wait), .stall2(stall2), .stall1(stall1),
    .ctl_rd_addr(ctl_rd_addr), .ctl_rd_en(ctl_rd_en),
    .vs_rd_addr(vs_rd_addr), .vs_rd_en(vs_rd_en), .op_s2(op_s2),
    .ctl_dst_s2(ctl_dst_s2), .vs_dst_s2(vs_dst_s2),
    .ctl_we_s2(ctl_we_s2), .vs_we_s2(vs_we_s2), .fwd_s2(fwd_s2)
  );

  vctl_regbank u_regbank (
    .clk(clk), .resetn(resetn),
    .ctl_rd_addr(ctl_rd_addr), .ctl_rd_en(ctl_rd_en),
    .vs_rd_addr(vs_rd_addr), .vs_rd_en(vs_rd_en),
    .fwd_s2(fwd_s2), .fwd_data(fwd_data),
    .ctl_wr_addr(ctl_wr_addr), .ctl_wr_en(ctl_wr_en), .ctl_wr_data(ctl_wr_data),
    .vs_wr_addr(vs_wr_addr), .vs_wr_en(vs_wr_en), .vs_wr_data(vs_wr_data),
    .ctl_rd_data(ctl_rd_data), .vs_rd_data(vs_rd_data), .vl(vl)
  );

  vctl_execute u_execute (
    .op_s2(op_s2), .ctl_dst_s2(ctl_dst_s2), .vs_dst_s2(vs_dst_s2),
    .ctl_we_s2(ctl_we_s2), .vs_we_s2(vs_we_s2), .stall3(stall3),
    .scalar_in(scalar_in), .scalar_in_en(scalar_in_en),
    .ctl_rd_data(ctl_rd_data), .vs_rd_data(vs_rd_data), .vl(vl),
    .stall2(stall2), .scalar_in_wait(scalar_in_wait),
    .ctl_wr_addr(ctl_wr_addr), .ctl_wr_en(ctl_wr_en), .ctl_wr_data(ctl_wr_data),
    .vs_wr_addr(vs_wr_addr), .vs_wr_en(vs_wr_en), .vs_wr_data(vs_wr_data),
    .fwd_data(fwd_data)
  );

  scalar_out_port u_out (
    .clk(clk), .resetn(resetn), .cfc_s2(cfc_s2), .ctl_rd_data(ctl_rd_data),
    .stall2(stall2), .scalar_out_wait(scalar_out_wait),
    .scalar_out(scalar_out), .scalar_out_en(scalar_out_en), .stall3(stall3)
  );

endmodule

`default_nettype wire

// File: test/tb_vctl.sv
// Drives vctl_top through a fixed-seed random instruction stream and needs a finite host back-pressure
`timescale 1ns/1ps
`default_nettype none
`include "vpu_params.svh"

module tb_vctl;

  localparam int TMO = 400;

  logic                   clk;
  logic                   resetn;
  logic [`VPU_WORD_W-1:0] instr;
  logic                   instr_en;
  logic                   instr_wait;
  logic [`VPU_WORD_W-1:0] scalar_in;
  logic                   scalar_in_en;
  logic                   scalar_in_wait;
  logic [`VPU_WORD_W-1:0] scalar_out;
  logic                   scalar_out_en;
  logic                   scalar_out_wait;

  logic [31:0] ctl_m [64];
  logic [31:0] vs_m [32];
  logic [31:0] exp_q [$];
  logic [31:0] in_q [$];
  logic [31:0] stim_rng;
  logic [31:0] feed_rng;
  logic [31:0] hold_rng;
  logic [5:0]  addrs [16];
  logic        in_taken;
  int          feed_delay;
  int          hold_len;

  vctl_top dut (
    .clk(clk), .resetn(resetn), .instr(instr), .instr_en(instr_en),
    .instr_wait(instr_wait), .scalar_in(scalar_in), .scalar_in_en(scalar_in_en),
    .scalar_in_wait(scalar_in_wait), .scalar_out(scalar_out),
    .scalar_out_en(scalar_out_en), .scalar_out_wait(scalar_out_wait)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp)
    begin
      $display("ERROR %s got %h expected %h", name, got, exp);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while %s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  // control form and move form encodings
  function automatic logic [31:0] mk_ctl(input logic [9:0] op, input logic [4:0] rt,
                                         input logic [5:0] vcr);
    return {`VPU_COP2_FIELD, op[9:6], 1'b0, rt, vcr, 4'b0, op[5:0]};
  endfunction

  function automatic logic [31:0] mk_mv(input logic [9:0] op, input logic [4:0] vsr);
    return {`VPU_COP2_FIELD, op[9:6], 1'b0, 5'b0, vsr, 5'b0, op[5:0]};
  endfunction

  // reference model, applied in issue order
  function automatic void model_apply(input logic [31:0] w, input logic [31:0] v);
    logic [9:0] op;
    logic [5:0] vcr;
    logic [4:0] rt;
    if (w[31:26] != `VPU_COP2_FIELD)
      return;
    op = {w[25:22], w[5:0]};
    vcr = w[15:10];
    rt = w[20:16];
    case (op)
      vpu_pkg::OP_CTC2:   ctl_m[vcr] = v;
      vpu_pkg::OP_MTC2:   vs_m[w[15:11]] = v;
      vpu_pkg::OP_CFC2:   exp_q.push_back(ctl_m[vcr]);
      vpu_pkg::OP_VMSTC:  ctl_m[vcr] = vs_m[rt];
      vpu_pkg::OP_VMCTS:  vs_m[rt] = ctl_m[vcr];
      vpu_pkg::OP_VHALF:  ctl_m[0] = ctl_m[0] / 2;
      vpu_pkg::OP_VSATVL: ctl_m[0] = (ctl_m[0] < `VPU_MVL) ? ctl_m[0] : `VPU_MVL;
      default: ;
    endcase
  endfunction

  task automatic send(input logic [31:0] w, input logic [31:0] v);
    int n;
    logic [9:0] op;
    n = 0;
    op = {w[25:22], w[5:0]};
    if (w[31:26] == `VPU_COP2_FIELD && (op == vpu_pkg::OP_CTC2 || op == vpu_pkg::OP_MTC2))
      in_q.push_back(v);
    @(negedge clk);
    instr = w;
    instr_en = 1'b1;
    #1;
    if (w[31:26] != `VPU_COP2_FIELD)
      check("instr_wait", {31'b0, instr_wait}, 32'h0);
    while (instr_wait)
    begin
      n++;
      if (n > TMO)
        fail_timeout("waiting for an instruction to be accepted");
      @(negedge clk);
      #1;
    end
    model_apply(w, v);
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(negedge clk);
      instr_en = 1'b0;
    end
  endtask

  task automatic send_random();
    logic [31:0] r;
    logic [31:0] w;
    stim_rng = xorshift(stim_rng);
    r = stim_rng;
    case (r[2:0])
      3'd0: send(mk_ctl(vpu_pkg::OP_CTC2, r[12:8], r[18:13]), xorshift(r));
      3'd1: send(mk_mv(vpu_pkg::OP_MTC2, r[12:8]), xorshift(r));
      3'd2: send(mk_ctl(vpu_pkg::OP_CFC2, r[12:8], r[18:13]), 32'h0);
      3'd3: send(mk_ctl(vpu_pkg::OP_VMSTC, r[12:8], r[18:13]), 32'h0);
      3'd4: send(mk_ctl(vpu_pkg::OP_VMCTS, r[12:8], r[18:13]), 32'h0);
      3'd5: send(mk_ctl(r[3] ? vpu_pkg::OP_VHALF : vpu_pkg::OP_VSATVL, 5'd0, 6'd0), 32'h0);
      3'd6: send(mk_ctl(10'b0011_101010, r[12:8], r[18:13]), 32'h0);
      default:
      begin
        // foreign word, never a coprocessor major opcode
        w = xorshift(r);
        if (w[31:26] == `VPU_COP2_FIELD)
          w[31] = ~w[31];
        send(w, 32'h0);
      end
    endcase
  endtask

  // host feeding scalar_in after a random delay
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (scalar_in_en && in_taken)
      begin
        void'(in_q.pop_front());
        scalar_in_en = 1'b0;
        feed_rng = xorshift(feed_rng);
        feed_delay = int'(feed_rng % 10);
      end
      else if (!scalar_in_en && in_q.size() > 0)
      begin
        if (feed_delay == 0)
        begin
          scalar_in_en = 1'b1;
          scalar_in = in_q[0];
        end
        else
          feed_delay--;
      end
      #1;
      in_taken = scalar_in_en && !scalar_in_wait;
    end
  end

  // random spells of output back-pressure
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (hold_len > 0)
        hold_len--;
      else
      begin
        hold_rng = xorshift(hold_rng);
        scalar_out_wait = (hold_rng[1:0] == 2'd0);
        hold_len = scalar_out_wait ? int'(hold_rng[7:4]) + 1 : int'(hold_rng[6:4]);
      end
    end
  end

  // compare each accepted result against the model
  initial
  begin
    forever
    begin
      @(negedge clk);
      #1;
      if (resetn && scalar_out_en && !scalar_out_wait)
      begin
        if (exp_q.size() == 0)
        begin
          $display("scalar_out strobed with no result expected");
          $display("TEST FAILED");
          $fatal(1);
        end
        else
          check("scalar_out", scalar_out, exp_q.pop_front());
      end
    end
  end

  initial
  begin
    int n;
    int j;
    logic [5:0] t;
    logic [31:0] vls [6];
    clk = 1'b0;
    resetn = 1'b0;
    instr = '0;
    instr_en = 1'b0;
    scalar_in = '0;
    scalar_in_en = 1'b0;
    scalar_out_wait = 1'b0;
    in_taken = 1'b0;
    feed_delay = 0;
    hold_len = 0;
    stim_rng = 32'd21;
    feed_rng = xorshift(32'd21);
    hold_rng = xorshift(xorshift(32'd21));
    for (int i = 0; i < 64; i++)
      ctl_m[i] = '0;
    for (int i = 0; i < 32; i++)
      vs_m[i] = '0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    resetn = 1'b1;

    // every bank written, then read back shuffled
    addrs[0] = 6'd5;
    addrs[1] = 6'd40;
    addrs[2] = 6'd50;
    addrs[3] = 6'd60;
    for (int i = 4; i < 16; i++)
    begin
      stim_rng = xorshift(stim_rng);
      addrs[i] = stim_rng[5:0];
    end
    for (int i = 0; i < 16; i++)
    begin
      stim_rng = xorshift(stim_rng);
      send(mk_ctl(vpu_pkg::OP_CTC2, 5'd0, addrs[i]), stim_rng);
    end
    for (int i = 15; i > 0; i--)
    begin
      stim_rng = xorshift(stim_rng);
      j = int'(stim_rng % (i + 1));
      t = addrs[i];
      addrs[i] = addrs[j];
      addrs[j] = t;
    end
    for (int i = 0; i < 16; i++)
      send(mk_ctl(vpu_pkg::OP_CFC2, 5'd0, addrs[i]), 32'h0);

    // scalar moves both ways, back to back
    send(mk_mv(vpu_pkg::OP_MTC2, 5'd5), 32'hcafe_0005);
    send(mk_ctl(vpu_pkg::OP_VMSTC, 5'd5, 6'd33), 32'h0);
    send(mk_ctl(vpu_pkg::OP_CFC2, 5'd0, 6'd33), 32'h0);
    send(mk_ctl(vpu_pkg::OP_VMCTS, 5'd9, 6'd40), 32'h0);
    send(mk_ctl(vpu_pkg::OP_VMSTC, 5'd9, 6'd20), 32'h0);
    send(mk_ctl(vpu_pkg::OP_CFC2, 5'd0, 6'd20), 32'h0);
    send(mk_ctl(vpu_pkg::OP_CTC2, 5'd0, 6'd57), 32'h1234_5678);
    send(mk_ctl(vpu_pkg::OP_CFC2, 5'd0, 6'd57), 32'h0);

    // vector length rules around the maximum
    vls = '{32'd10, 32'd63, 32'd64, 32'd65, 32'd200, 32'hffff_ffff};
    for (int i = 0; i < 6; i++)
    begin
      send(mk_ctl(vpu_pkg::OP_CTC2, 5'd0, 6'd0), vls[i]);
      send(mk_ctl(vpu_pkg::OP_VSATVL, 5'd0, 6'd0), 32'h0);
      send(mk_ctl(vpu_pkg::OP_CFC2, 5'd0, 6'd0), 32'h0);
      send(mk_ctl(vpu_pkg::OP_VHALF, 5'd0, 6'd0), 32'h0);
      send(mk_ctl(vpu_pkg::OP_CFC2, 5'd0, 6'd0), 32'h0);
    end

    // random mix with foreign words and gaps
    for (int i = 0; i < 300; i++)
    begin
      send_random();
      if (stim_rng[9:8] == 2'd0)
        idle(int'(stim_rng[11:10]) + 1);
    end

    // full sweep shows nothing else changed
    for (int i = 0; i < 64; i++)
      send(mk_ctl(vpu_pkg::OP_CFC2, 5'd0, 6'(i)), 32'h0);
    idle(1);

    n = 0;
    while (exp_q.size() > 0 || in_q.size() > 0)
    begin
      n++;
      if (n > TMO)
        fail_timeout("draining the expected results");
      @(negedge clk);
    end
    // a late duplicate strobe would still be caught here
    idle(4);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
+incdir+common
common/vpu_pkg.sv
ctlregs/vctl_regfile.sv
ctlregs/vctl_regbank.sv
logic/vctl_decode.sv
logic/vctl_execute.sv
logic/scalar_out_port.sv
logic/vctl_top.sv
test/tb_vctl.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module tb_vctl -o sim_tb
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

out="$(./obj_dir/sim_tb)"
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "TEST OK"; then
  exit 0
fi
exit 1
